// File: test/rv_cases.txt
# P <word index hex> <instruction hex> | R <register dec> <expected hex> | E ends a case
# case 1: bypass at distance 1, 2, 3 and x0 writes dropped
P 00 00500093  # addi x1, x0, 5
P 01 00308113  # addi x2, x1, 3
P 02 002081b3  # add  x3, x1, x2
P 03 00308233  # add  x4, x1, x3
P 04 00700013  # addi x0, x0, 7
P 05 00100333  # add  x6, x0, x1
P 06 002203b3  # add  x7, x4, x2
P 07 ffffffff  # invalid
R 0 00000000
R 1 00000005
R 2 00000008
R 3 0000000d
R 4 00000012
R 6 00000005
R 7 0000001a
E
# case 2: store then load, load-use stall, alu functions
P 00 12300093  # addi x1, x0, 0x123
P 01 00800113  # addi x2, x0, 8
P 02 00112223  # sw   x1, 4(x2)
P 03 00412183  # lw   x3, 4(x2)
P 04 00118233  # add  x4, x3, x1
P 05 402202b3  # sub  x5, x4, x2
P 06 ff000313  # addi x6, x0, -16
P 07 0062f3b3  # and  x7, x5, x6
P 08 0020e433  # or   x8, x1, x2
P 09 001444b3  # xor  x9, x8, x1
P 0a 40110533  # sub  x10, x2, x1
P 0b ffffffff  # invalid
R 3 00000123
R 4 00000246
R 5 0000023e
R 6 fffffff0
R 7 00000230
R 8 0000012b
R 9 00000008
R 10 fffffee5
E
# case 3: taken and not-taken beq, halt blocks the next word
P 00 00100093  # addi x1, x0, 1
P 01 00100113  # addi x2, x0, 1
P 02 00200193  # addi x3, x0, 2
P 03 05500513  # addi x10, x0, 0x55
P 04 06600593  # addi x11, x0, 0x66
P 05 04400713  # addi x14, x0, 0x44
P 06 00208663  # beq  x1, x2, +12
P 07 00100513  # addi x10, x0, 1
P 08 00200593  # addi x11, x0, 2
P 09 00308463  # beq  x1, x3, +8
P 0a 07700613  # addi x12, x0, 0x77
P 0b 00160693  # addi x13, x12, 1
P 0c ffffffff  # invalid
P 0d 09900713  # addi x14, x0, 0x99
R 10 00000055
R 11 00000066
R 12 00000077
R 13 00000078
R 14 00000044
E

// File: filelist.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_mem.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_ctrl.sv
hdl/rv_core.sv
hdl/rv_top.sv
test/rv_clk_gen.sv
test/rv_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module rv_tb -Mdir obj_dir -o rv_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/rv_tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// File: test/rv_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_tb import rv_pkg::*;
();

    localparam int LOAD_AW     = $clog2(`RV_IMEM_WORDS);
    localparam int HALT_CYCLES = 500;
    localparam int RESET_WAIT  = 10;

    logic               clk;
    logic               reset_n;
    logic               reset_req;
    logic               run;
    logic               load_we;
    logic [LOAD_AW-1:0] load_addr;
    word_t              load_data;
    reg_addr_t          dbg_addr;
    word_t              dbg_rdata;
    logic               halted;

    // program and expected registers of the case being read
    logic [LOAD_AW-1:0] prog_addr [$];
    word_t              prog_word [$];
    reg_addr_t          exp_reg [$];
    word_t              exp_val [$];

    rv_clk_gen #(.HALF_PERIOD(10)) u_clk_gen
    (
        .i_reset_req (reset_req),
        .o_clk       (clk),
        .o_reset_n   (reset_n)
    );

    rv_top u_dut
    (
        .i_clk       (clk),
        .i_reset_n   (reset_n),
        .i_run       (run),
        .i_load_we   (load_we),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .i_dbg_addr  (dbg_addr),
        .o_dbg_rdata (dbg_rdata),
        .o_halted    (halted)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation aborted");
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_reg(input reg_addr_t r, input word_t expected, input word_t actual);
        if (actual !== expected)
            abort_run($sformatf("ERROR o_dbg_rdata x%0d: expected 0x%08h, actual 0x%08h",
                                r, expected, actual));
    endtask

    task automatic reset_core();
        int waited;
        run       = 1'b0;
        load_we   = 1'b0;
        reset_req = 1'b1;
        next_cycle();
        reset_req = 1'b0;
        waited    = 0;
        while (!reset_n && waited < RESET_WAIT)
        begin
            next_cycle();
            waited++;
        end
        if (!reset_n)
            abort_run("reset was never released");
    endtask

    task automatic load_program();
        foreach (prog_word[i])
        begin
            load_we   = 1'b1;
            load_addr = prog_addr[i];
            load_data = prog_word[i];
            next_cycle();
        end
        load_we = 1'b0;
        next_cycle();
    endtask

    task automatic run_until_halt(input int case_num);
        int waited;
        run    = 1'b1;
        waited = 0;
        while (!halted && waited < HALT_CYCLES)
        begin
            next_cycle();
            waited++;
        end
        if (!halted)
            abort_run($sformatf("case %0d: the core did not halt within %0d cycles",
                                case_num, HALT_CYCLES));
    endtask

    // debug data shows up one cycle after the address
    task automatic read_reg(input reg_addr_t r, output word_t value);
        dbg_addr = r;
        next_cycle();
        value = dbg_rdata;
    endtask

    task automatic run_case(input int case_num);
        word_t actual;
        reset_core();
        load_program();
        run_until_halt(case_num);
        // older instructions drain into the register file
        repeat (4) next_cycle();
        foreach (exp_reg[i])
        begin
            read_reg(exp_reg[i], actual);
            check_reg(exp_reg[i], exp_val[i], actual);
        end
        run = 1'b0;
        $display("case %0d: %0d registers checked", case_num, exp_reg.size());
        prog_addr.delete();
        prog_word.delete();
        exp_reg.delete();
        exp_val.delete();
    endtask

    initial
    begin
        int               fd;
        int               code;
        int               num;
        int               cases_run;
        logic [7:0]       tag;
        logic [31:0]      word;
        logic [8*128-1:0] rest;
        logic             done;
        reset_req = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        cases_run = 0;
        done      = 1'b0;
        fd = $fopen("test/rv_cases.txt", "r");
        if (fd == 0)
            abort_run("cannot open test/rv_cases.txt");
        while (!done)
        begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1)
                done = 1'b1;
            else if (tag == "#")
                code = $fgets(rest, fd);
            else if (tag == "P")
            begin
                code = $fscanf(fd, "%h %h", num, word);
                if (code != 2 || num < 0 || num >= `RV_IMEM_WORDS)
                    abort_run("malformed program line in the case file");
                prog_addr.push_back(num[LOAD_AW-1:0]);
                prog_word.push_back(word);
            end
            else if (tag == "R")
            begin
                code = $fscanf(fd, "%d %h", num, word);
                if (code != 2 || num < 0 || num > 31)
                    abort_run("malformed register line in the case file");
                exp_reg.push_back(num[4:0]);
                exp_val.push_back(word);
            end
            else if (tag == "E")
            begin
                cases_run++;
                run_case(cases_run);
            end
            else
                abort_run("unknown line type in the case file");
        end
        $fclose(fd);
        if (cases_run == 0)
            abort_run("the case file holds no case");
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: test/rv_clk_gen.sv
`timescale 1ns/1ps

module rv_clk_gen
#(
    parameter int HALF_PERIOD = 10
)
(
    input  logic i_reset_req,
    output logic o_clk,
    output logic o_reset_n
);

    logic [1:0] reset_cnt = 2'd2;

    initial
        o_clk = 1'b0;

    always #HALF_PERIOD o_clk = ~o_clk;

    // reset stays low for two rising edges after a request
    always @(posedge o_clk)
    begin
        if (i_reset_req)
            reset_cnt <= 2'd2;
        else if (reset_cnt != 2'd0)
            reset_cnt <= reset_cnt - 2'd1;
    end

    assign o_reset_n = (reset_cnt == 2'd0);

endmodule

// File: hdl/rv_top.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_top import rv_pkg::*;
(
    input  logic                              i_clk,
    input  logic                              i_reset_n,
    input  logic                              i_run,
    input  logic                              i_load_we,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0] i_load_addr,
    input  word_t                             i_load_data,
    input  reg_addr_t                         i_dbg_addr,
    output word_t                             o_dbg_rdata,
    output logic                              o_halted
);

    reg_addr_t  decode_rs1, decode_rs2, exec_rs1, exec_rs2, exec_rd;
    reg_addr_t  memory_rd, write_rd, write_back_rd, rf_waddr;
    logic       decode_inv, exec_pc_sel, memory_reg_write, write_reg_write;
    logic       write_back_write, rf_we;
    logic       fetch_stall, decode_stall, decode_flush, exec_flush;
    res_src_t   exec_res_src;
    bp_sel_t    bp_rs1, bp_rs2;
    word_t      rf_rdata1, rf_rdata2, rf_wdata;

    rv_core u_core
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_run              (i_run),
        .i_load_we          (i_load_we),
        .i_load_addr        (i_load_addr),
        .i_load_data        (i_load_data),
        .i_rf_rdata1        (rf_rdata1),
        .i_rf_rdata2        (rf_rdata2),
        .o_rf_we            (rf_we),
        .o_rf_waddr         (rf_waddr),
        .o_rf_wdata         (rf_wdata),
        .o_decode_rs1       (decode_rs1),
        .o_decode_rs2       (decode_rs2),
        .o_decode_inv_instr (decode_inv),
        .o_exec_rs1         (exec_rs1),
        .o_exec_rs2         (exec_rs2),
        .o_exec_rd          (exec_rd),
        .o_exec_pc_sel      (exec_pc_sel),
        .o_exec_res_src     (exec_res_src),
        .o_memory_rd        (memory_rd),
        .o_memory_reg_write (memory_reg_write),
        .o_write_rd         (write_rd),
        .o_write_reg_write  (write_reg_write),
        .o_write_back_rd    (write_back_rd),
        .o_write_back_write (write_back_write),
        .i_exec_bp_rs1      (bp_rs1),
        .i_exec_bp_rs2      (bp_rs2),
        .i_fetch_stall      (fetch_stall),
        .i_decode_stall     (decode_stall),
        .i_decode_flush     (decode_flush),
        .i_exec_flush       (exec_flush)
    );

    // operands are read while the instruction sits in decode
    rv_regfile u_regfile
    (
        .i_clk       (i_clk),
        .i_rd_addr1  (decode_rs1),
        .i_rd_addr2  (decode_rs2),
        .o_rd_data1  (rf_rdata1),
        .o_rd_data2  (rf_rdata2),
        .i_wr_en     (rf_we),
        .i_wr_addr   (rf_waddr),
        .i_wr_data   (rf_wdata),
        .i_dbg_addr  (i_dbg_addr),
        .o_dbg_rdata (o_dbg_rdata)
    );

    rv_ctrl u_ctrl
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_decode_rs1       (decode_rs1),
        .i_decode_rs2       (decode_rs2),
        .i_decode_inv_instr (decode_inv),
        .i_exec_rs1         (exec_rs1),
        .i_exec_rs2         (exec_rs2),
        .i_exec_rd          (exec_rd),
        .i_exec_pc_sel      (exec_pc_sel),
        .i_exec_res_src     (exec_res_src),
        .i_memory_rd        (memory_rd),
        .i_memory_reg_write (memory_reg_write),
        .i_write_rd         (write_rd),
        .i_write_reg_write  (write_reg_write),
        .i_write_back_rd    (write_back_rd),
        .i_write_back_write (write_back_write),
        .o_exec_bp_rs1      (bp_rs1),
        .o_exec_bp_rs2      (bp_rs2),
        .o_fetch_stall      (fetch_stall),
        .o_decode_stall     (decode_stall),
        .o_decode_flush     (decode_flush),
        .o_exec_flush       (exec_flush),
        .o_halted           (o_halted)
    );

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core import rv_pkg::*;
(
    input  logic                              i_clk,
    input  logic                              i_reset_n,
    input  logic                              i_run,
    input  logic                              i_load_we,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0] i_load_addr,
    input  word_t                             i_load_data,
    // register file
    input  word_t                             i_rf_rdata1,
    input  word_t                             i_rf_rdata2,
    output logic                              o_rf_we,
    output reg_addr_t                         o_rf_waddr,
    output word_t                             o_rf_wdata,
    // hazard controller
    output reg_addr_t                         o_decode_rs1,
    output reg_addr_t                         o_decode_rs2,
    output logic                              o_decode_inv_instr,
    output reg_addr_t                         o_exec_rs1,
    output reg_addr_t                         o_exec_rs2,
    output reg_addr_t                         o_exec_rd,
    output logic                              o_exec_pc_sel,
    output res_src_t                          o_exec_res_src,
    output reg_addr_t                         o_memory_rd,
    output logic                              o_memory_reg_write,
    output reg_addr_t                         o_write_rd,
    output logic                              o_write_reg_write,
    output reg_addr_t                         o_write_back_rd,
    output logic                              o_write_back_write,
    input  bp_sel_t                           i_exec_bp_rs1,
    input  bp_sel_t                           i_exec_bp_rs2,
    input  logic                              i_fetch_stall,
    input  logic                              i_decode_stall,
    input  logic                              i_decode_flush,
    input  logic                              i_exec_flush
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    pc_t                pc_q;
    pc_t                dec_pc;
    logic               dec_valid;
    word_t              dec_instr;
    ctrl_t              dec_ctrl;
    reg_addr_t          dec_rd;
    word_t              dec_imm;
    logic               dec_invalid;
    logic [IMEM_AW-1:0] imem_addr;

    exec_stage_t        ex_q;
    mem_stage_t         mem_q;
    wr_stage_t          wr_q;
    logic               wb_write;
    reg_addr_t          wb_rd;
    word_t              wb_data;

    word_t              op_a;
    word_t              op_b;
    word_t              alu_b;
    word_t              alu_res;
    pc_t                br_target;
    logic               pc_sel;
    word_t              dmem_rdata;
    word_t              wr_result;

    function automatic word_t bp_mux(input bp_sel_t sel, input word_t direct,
                                     input word_t from_mem, input word_t from_wr,
                                     input word_t from_wb);
        case (sel)
            `RV_BP_MEMORY:   return from_mem;
            `RV_BP_WRITE:    return from_wr;
            `RV_BP_WRITE_BK: return from_wb;
            default:         return direct;
        endcase
    endfunction

    // fetch
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc_q <= '0;
        else if (pc_sel)
            pc_q <= br_target;
        else if (i_run && !i_fetch_stall)
            pc_q <= pc_q + 32'd4;
    end

    // a held decode re-reads its own word so the memory output stays put
    always_comb
    begin
        if (i_load_we)
            imem_addr = i_load_addr;
        else if (i_fetch_stall)
            imem_addr = dec_pc[IMEM_AW+1:2];
        else
            imem_addr = pc_q[IMEM_AW+1:2];
    end

    rv_mem #(.DEPTH(`RV_IMEM_WORDS)) u_imem
    (
        .i_clk   (i_clk),
        .i_we    (i_load_we),
        .i_addr  (imem_addr),
        .i_wdata (i_load_data),
        .o_rdata (dec_instr)
    );

    // decode
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_decode_flush)
            dec_valid <= 1'b0;
        else if (!i_decode_stall)
            dec_valid <= i_run;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_run && !i_decode_stall)
            dec_pc <= pc_q;
    end

    rv_decode u_decode
    (
        .i_instr   (dec_instr),
        .o_ctrl    (dec_ctrl),
        .o_rs1     (o_decode_rs1),
        .o_rs2     (o_decode_rs2),
        .o_rd      (dec_rd),
        .o_imm     (dec_imm),
        .o_invalid (dec_invalid)
    );

    assign o_decode_inv_instr = dec_valid & dec_invalid;

    // execute
    always_ff @(posedge i_clk)
    begin
        ex_q <= '{ctrl: dec_ctrl, pc: dec_pc, rs1: o_decode_rs1, rs2: o_decode_rs2,
                  rd: dec_rd, imm: dec_imm};
        if (!i_reset_n || i_exec_flush || !dec_valid)
            ex_q.ctrl <= '0;
    end

    assign op_a = bp_mux(i_exec_bp_rs1, i_rf_rdata1, mem_q.alu_result, wr_result, wb_data);
    assign op_b = bp_mux(i_exec_bp_rs2, i_rf_rdata2, mem_q.alu_result, wr_result, wb_data);

    always_comb
    begin
        alu_b = ex_q.ctrl.use_imm ? ex_q.imm : op_b;
        case (ex_q.ctrl.alu_op)
            `RV_ALU_SUB: alu_res = op_a - alu_b;
            `RV_ALU_AND: alu_res = op_a & alu_b;
            `RV_ALU_OR:  alu_res = op_a | alu_b;
            `RV_ALU_XOR: alu_res = op_a ^ alu_b;
            default:     alu_res = op_a + alu_b;
        endcase
    end

    assign br_target = ex_q.pc + ex_q.imm;
    assign pc_sel    = ex_q.ctrl.valid & ex_q.ctrl.branch & (op_a == op_b);

    // memory
    always_ff @(posedge i_clk)
    begin
        mem_q <= '{ctrl: ex_q.ctrl, rd: ex_q.rd, alu_result: alu_res, store_data: op_b};
        if (!i_reset_n)
            mem_q.ctrl <= '0;
    end

    rv_mem #(.DEPTH(`RV_DMEM_WORDS)) u_dmem
    (
        .i_clk   (i_clk),
        .i_we    (mem_q.ctrl.mem_write),
        .i_addr  (mem_q.alu_result[DMEM_AW+1:2]),
        .i_wdata (mem_q.store_data),
        .o_rdata (dmem_rdata)
    );

    // write stage where load data arrives
    always_ff @(posedge i_clk)
    begin
        wr_q <= '{reg_write: mem_q.ctrl.reg_write, res_src: mem_q.ctrl.res_src,
                  rd: mem_q.rd, alu_result: mem_q.alu_result};
        if (!i_reset_n)
            wr_q.reg_write <= 1'b0;
    end

    assign wr_result = (wr_q.res_src == `RV_RES_MEMORY) ? dmem_rdata : wr_q.alu_result;

    // covers the cycle where the register file still returns the old value
    always_ff @(posedge i_clk)
    begin
        wb_rd    <= wr_q.rd;
        wb_data  <= wr_result;
        wb_write <= i_reset_n ? wr_q.reg_write : 1'b0;
    end

    assign o_rf_we            = wr_q.reg_write;
    assign o_rf_waddr         = wr_q.rd;
    assign o_rf_wdata         = wr_result;
    assign o_exec_rs1         = ex_q.rs1;
    assign o_exec_rs2         = ex_q.rs2;
    assign o_exec_rd          = ex_q.rd;
    assign o_exec_pc_sel      = pc_sel;
    assign o_exec_res_src     = ex_q.ctrl.res_src;
    assign o_memory_rd        = mem_q.rd;
    assign o_memory_reg_write = mem_q.ctrl.reg_write;
    assign o_write_rd         = wr_q.rd;
    assign o_write_reg_write  = wr_q.reg_write;
    assign o_write_back_rd    = wb_rd;
    assign o_write_back_write = wb_write;

endmodule

// File: hdl/rv_ctrl.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_ctrl import rv_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  reg_addr_t   i_decode_rs1,
    input  reg_addr_t   i_decode_rs2,
    input  logic        i_decode_inv_instr,
    input  reg_addr_t   i_exec_rs1,
    input  reg_addr_t   i_exec_rs2,
    input  reg_addr_t   i_exec_rd,
    input  logic        i_exec_pc_sel,
    input  res_src_t    i_exec_res_src,
    input  reg_addr_t   i_memory_rd,
    input  logic        i_memory_reg_write,
    input  reg_addr_t   i_write_rd,
    input  logic        i_write_reg_write,
    input  reg_addr_t   i_write_back_rd,
    input  logic        i_write_back_write,
    output bp_sel_t     o_exec_bp_rs1,
    output bp_sel_t     o_exec_bp_rs2,
    output logic        o_fetch_stall,
    output logic        o_decode_stall,
    output logic        o_decode_flush,
    output logic        o_exec_flush,
    output logic        o_halted
);

    logic r_halted;
    logic w_inv_decode;
    logic w_load_stall;
    logic w_hold;

    // youngest producer wins and x0 is never forwarded
    function automatic bp_sel_t pick_bp(input reg_addr_t rs);
        bp_sel_t sel;
        if (rs == '0)
            sel = `RV_BP_DIRECT;
        else if (i_memory_reg_write && (rs == i_memory_rd))
            sel = `RV_BP_MEMORY;
        else if (i_write_reg_write && (rs == i_write_rd))
            sel = `RV_BP_WRITE;
        else if (i_write_back_write && (rs == i_write_back_rd))
            sel = `RV_BP_WRITE_BK;
        else
            sel = `RV_BP_DIRECT;
        return sel;
    endfunction

    always_comb
    begin
        o_exec_bp_rs1 = pick_bp(i_exec_rs1);
        o_exec_bp_rs2 = pick_bp(i_exec_rs2);
    end

    // a bad word on the wrong side of a taken branch is discarded, not fatal
    assign w_inv_decode = i_decode_inv_instr & ~i_exec_pc_sel;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_halted <= 1'b0;
        else if (w_inv_decode)
            r_halted <= 1'b1;
    end

    // load data only exists from the write stage on
    assign w_load_stall = (i_exec_res_src == `RV_RES_MEMORY) &&
                          ((i_decode_rs1 == i_exec_rd) || (i_decode_rs2 == i_exec_rd));

    assign w_hold         = w_load_stall | w_inv_decode | r_halted;
    assign o_fetch_stall  = w_hold;
    assign o_decode_stall = w_hold;
    assign o_decode_flush = i_exec_pc_sel;
    assign o_exec_flush   = i_exec_pc_sel | w_hold;
    assign o_halted       = r_halted;

    a_no_bp_x0: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(((i_exec_rs1 == '0) && (o_exec_bp_rs1 != `RV_BP_DIRECT)) ||
          ((i_exec_rs2 == '0) && (o_exec_bp_rs2 != `RV_BP_DIRECT))));

    // a held decode must never leak a copy into execute
    a_stall_bubble: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_decode_stall |-> o_exec_flush);

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*;
(
    input  logic        i_clk,
    input  reg_addr_t   i_rd_addr1,
    input  reg_addr_t   i_rd_addr2,
    output word_t       o_rd_data1,
    output word_t       o_rd_data2,
    input  logic        i_wr_en,
    input  reg_addr_t   i_wr_addr,
    input  word_t       i_wr_data,
    input  reg_addr_t   i_dbg_addr,
    output word_t       o_dbg_rdata
);

    word_t regs [32];

    // reads see the value from before a same-cycle write
    always_ff @(posedge i_clk)
    begin
        if (i_wr_en && (i_wr_addr != '0))
            regs[i_wr_addr] <= i_wr_data;
        o_rd_data1  <= (i_rd_addr1 == '0) ? '0 : regs[i_rd_addr1];
        o_rd_data2  <= (i_rd_addr2 == '0) ? '0 : regs[i_rd_addr2];
        o_dbg_rdata <= (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];
    end

    a_x0_read1: assert property (@(posedge i_clk)
        (i_rd_addr1 == '0) |=> (o_rd_data1 == '0));

    a_x0_read2: assert property (@(posedge i_clk)
        (i_rd_addr2 == '0) |=> (o_rd_data2 == '0));

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode import rv_pkg::*;
(
    input  word_t       i_instr,
    output ctrl_t       o_ctrl,
    output reg_addr_t   o_rs1,
    output reg_addr_t   o_rs2,
    output reg_addr_t   o_rd,
    output word_t       o_imm,
    output logic        o_invalid
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rd   = i_instr[11:7];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];

    always_comb
    begin
        o_ctrl         = '0;
        o_ctrl.alu_op  = `RV_ALU_ADD;
        o_ctrl.res_src = `RV_RES_ALU;
        // I-type by default
        o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        case (opcode)
            `RV_OP_REG:
            begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.valid     = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: o_ctrl.alu_op = `RV_ALU_ADD;
                    {7'h20, 3'b000}: o_ctrl.alu_op = `RV_ALU_SUB;
                    {7'h00, 3'b100}: o_ctrl.alu_op = `RV_ALU_XOR;
                    {7'h00, 3'b110}: o_ctrl.alu_op = `RV_ALU_OR;
                    {7'h00, 3'b111}: o_ctrl.alu_op = `RV_ALU_AND;
                    default:         o_ctrl.valid  = 1'b0;
                endcase
            end
            `RV_OP_IMM:
            begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.valid     = (funct3 == 3'b000);
            end
            `RV_OP_LOAD:
            begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.res_src   = `RV_RES_MEMORY;
                o_ctrl.valid     = (funct3 == 3'b010);
            end
            `RV_OP_STORE:
            begin
                o_ctrl.mem_write = 1'b1;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.valid     = (funct3 == 3'b010);
                o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            end
            `RV_OP_BRANCH:
            begin
                o_ctrl.branch = 1'b1;
                o_ctrl.valid  = (funct3 == 3'b000);
                o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                         i_instr[30:25], i_instr[11:8], 1'b0};
            end
            default:
            begin
                o_ctrl.valid = 1'b0;
            end
        endcase
        // unsupported words turn into bubbles
        if (!o_ctrl.valid)
            o_ctrl = '0;
        o_invalid = !o_ctrl.valid && (i_instr != '0);
    end

endmodule

// File: hdl/rv_mem.sv
`timescale 1ns/1ps

module rv_mem import rv_pkg::*;
#(
    parameter int DEPTH = 64
)
(
    input  logic                     i_clk,
    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_addr,
    input  word_t                    i_wdata,
    output word_t                    o_rdata
);

    word_t mem [DEPTH];

    // registered read with one cycle latency
    always_ff @(posedge i_clk)
    begin
        if (i_we)
            mem[i_addr] <= i_wdata;
        o_rdata <= mem[i_addr];
    end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] pc_t;
    typedef logic [1:0]  res_src_t;
    typedef logic [1:0]  bp_sel_t;
    typedef logic [2:0]  alu_op_t;

    // all zero is a bubble
    typedef struct packed {
        alu_op_t    alu_op;
        res_src_t   res_src;
        logic       reg_write;
        logic       mem_write;
        logic       use_imm;
        logic       branch;
        logic       valid;
    } ctrl_t;

    typedef struct packed {
        ctrl_t      ctrl;
        pc_t        pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      imm;
    } exec_stage_t;

    typedef struct packed {
        ctrl_t      ctrl;
        reg_addr_t  rd;
        word_t      alu_result;
        word_t      store_data;
    } mem_stage_t;

    typedef struct packed {
        logic       reg_write;
        res_src_t   res_src;
        reg_addr_t  rd;
        word_t      alu_result;
    } wr_stage_t;

endpackage

// File: hdl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// write stage result source
`define RV_RES_ALU          2'd0
`define RV_RES_MEMORY       2'd1

// execute operand bypass select
`define RV_BP_DIRECT        2'd0
`define RV_BP_MEMORY        2'd1
`define RV_BP_WRITE         2'd2
`define RV_BP_WRITE_BK      2'd3

// major opcodes
`define RV_OP_REG           7'b0110011
`define RV_OP_IMM           7'b0010011
`define RV_OP_LOAD          7'b0000011
`define RV_OP_STORE         7'b0100011
`define RV_OP_BRANCH        7'b1100011

// alu functions
`define RV_ALU_ADD          3'd0
`define RV_ALU_SUB          3'd1
`define RV_ALU_AND          3'd2
`define RV_ALU_OR           3'd3
`define RV_ALU_XOR          3'd4

// memory sizes in 32-bit words
`define RV_IMEM_WORDS       64
`define RV_DMEM_WORDS       64

`endif
